// File: sources.f
+incdir+verilog
verilog/uop_pkg.sv
verilog/exec_pkg.sv
verilog/alu.sv
verilog/branch_unit.sv
verilog/imul.sv
verilog/idiv.sv
verilog/wb_scheduler.sv
verilog/exec_unit.sv
tb/exec_unit_sva.sv
tb/exec_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module exec_unit_tb -o exec_unit_sim
output=$(./obj_dir/exec_unit_sim)
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
  exit 0
else
  exit 1
fi

// File: tb/exec_unit_tb.sv
// testbench for the execute stage
// table driven issue, results matched by rd tag, latency and redirect checks
`timescale 1ns/1ns
`default_nettype none
`include "exec_settings.svh"

module exec_unit_tb;

  localparam int N_ROWS      = 38;
  localparam int COLLIDE_ROW = 24;  // alu right behind the multiplies
  localparam int DIV2_ROW    = 26;  // second divide

  typedef struct {
    uop_pkg::fu_code_t fu;
    logic [3:0]        op;
    logic [31:0]       pc, imm, in1, in2;
    logic              has_wb;
    logic [31:0]       exp_data;
    logic              has_redir;
    logic [31:0]       exp_target;
  } row_t;

  logic                clock;
  logic                reset;
  uop_pkg::micro_op_t  uop;
  logic [31:0]         in1, in2;
  logic                stall;
  exec_pkg::wb_t       wb;
  exec_pkg::redirect_t redirect;

  row_t rows [N_ROWS];
  logic done [N_ROWS];
  logic stalled [N_ROWS];
  int   acc_cycle [N_ROWS];
  int   n_rows = 0;
  int   n_wb = 0;
  int   errors = 0;
  int   completions = 0;
  int   cycle = 0;

  exec_unit exec_unit_inst (
    .clock(clock), .reset(reset), .uop(uop), .in1(in1), .in2(in2),
    .stall(stall), .wb(wb), .redirect(redirect)
  );

  always #2 clock = ~clock;

  always @(posedge clock) cycle <= cycle + 1;

  task automatic add_row(input uop_pkg::fu_code_t fu, input logic [3:0] op,
                         input logic [31:0] pc, imm, a, b,
                         input logic has_wb, input logic [31:0] data,
                         input logic has_redir, input logic [31:0] target);
    rows[n_rows] = '{fu, op, pc, imm, a, b, has_wb, data, has_redir, target};
    done[n_rows] = 1'b0;
    stalled[n_rows] = 1'b0;
    if (has_wb) n_wb++;
    n_rows++;
  endtask

  // alu, multiply and divide rows always write rd
  task automatic calc_row(input uop_pkg::fu_code_t fu, input logic [3:0] op,
                          input logic [31:0] a, b, data);
    add_row(fu, op, 32'h0, 32'h0, a, b, 1'b1, data, 1'b0, 32'h0);
  endtask

  task automatic branch_row(input logic [3:0] op, input logic [31:0] pc, imm, a, b,
                            input logic taken, input logic [31:0] target, link);
    logic is_jump;
    is_jump = (op == uop_pkg::BR_JAL) || (op == uop_pkg::BR_JALR);
    add_row(uop_pkg::FU_BR, op, pc, imm, a, b, is_jump, link, taken, target);
  endtask

  // rd tag is the row number mod 32
  // rows 0-5 and 32-37 share tags and never write
  task automatic build_table();
    branch_row(uop_pkg::BR_EQ,  32'h100, 32'h20, 32'h5, 32'h5, 1'b1, 32'h120, 32'h0);
    branch_row(uop_pkg::BR_NE,  32'h200, 32'hFFFFFFF0, 32'h1, 32'h2, 1'b1, 32'h1F0, 32'h0);
    branch_row(uop_pkg::BR_LT,  32'h300, 32'h8, 32'hFFFFFFFF, 32'h1, 1'b1, 32'h308, 32'h0);
    branch_row(uop_pkg::BR_GE,  32'h400, 32'h10, 32'h7, 32'h7, 1'b1, 32'h410, 32'h0);
    branch_row(uop_pkg::BR_GE,  32'h480, 32'h10, 32'hFFFFFFFE, 32'h3, 1'b0, 32'h0, 32'h0);
    branch_row(uop_pkg::BR_LTU, 32'h500, 32'h4, 32'h1, 32'hFFFFFFFF, 1'b1, 32'h504, 32'h0);
    calc_row(uop_pkg::FU_ALU, uop_pkg::ALU_ADD,  32'h5, 32'h7, 32'h0000000C);
    calc_row(uop_pkg::FU_ALU, uop_pkg::ALU_SUB,  32'h5, 32'h7, 32'hFFFFFFFE);
    calc_row(uop_pkg::FU_ALU, uop_pkg::ALU_SLT,  32'hFFFFFFFF, 32'h1, 32'h1);
    calc_row(uop_pkg::FU_ALU, uop_pkg::ALU_SLTU, 32'hFFFFFFFF, 32'h1, 32'h0);
    calc_row(uop_pkg::FU_ALU, uop_pkg::ALU_XOR,  32'hF0F0F0F0, 32'h0FF00FF0, 32'hFF00FF00);
    calc_row(uop_pkg::FU_ALU, uop_pkg::ALU_OR,   32'hF0F00000, 32'h0000F0F0, 32'hF0F0F0F0);
    calc_row(uop_pkg::FU_ALU, uop_pkg::ALU_AND,  32'h12345678, 32'h0F0F0F0F, 32'h02040608);
    calc_row(uop_pkg::FU_ALU, uop_pkg::ALU_SLL,  32'h1, 32'h24, 32'h10);  // shamt 4
    calc_row(uop_pkg::FU_ALU, uop_pkg::ALU_SRL,  32'h80000000, 32'hFFFFFFFF, 32'h1);
    calc_row(uop_pkg::FU_ALU, uop_pkg::ALU_SRA,  32'h80000000, 32'h104, 32'hF8000000);
    calc_row(uop_pkg::FU_ALU, uop_pkg::ALU_SLT,  32'h1, 32'h80000000, 32'h0);
    calc_row(uop_pkg::FU_ALU, uop_pkg::ALU_SLTU, 32'h1, 32'h80000000, 32'h1);
    branch_row(uop_pkg::BR_JAL, 32'h600, 32'h100, 32'h0, 32'h0, 1'b1, 32'h700, 32'h604);
    branch_row(uop_pkg::BR_JALR, 32'h800, 32'h10, 32'h1001, 32'h0, 1'b1, 32'h1010, 32'h804);
    calc_row(uop_pkg::FU_MUL, uop_pkg::MUL_MUL,    32'h12345678, 32'h2, 32'h2468ACF0);
    calc_row(uop_pkg::FU_MUL, uop_pkg::MUL_MULH,   32'hFFFFFFFE, 32'h3, 32'hFFFFFFFF);
    calc_row(uop_pkg::FU_MUL, uop_pkg::MUL_MULHSU, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'hFFFFFFFF);
    calc_row(uop_pkg::FU_MUL, uop_pkg::MUL_MULHU,  32'hFFFFFFFF, 32'hFFFFFFFF, 32'hFFFFFFFE);
    calc_row(uop_pkg::FU_ALU, uop_pkg::ALU_ADD,  32'h100, 32'h23, 32'h123);
    calc_row(uop_pkg::FU_DIV, uop_pkg::DIV_DIV,  32'hFFFFFFF9, 32'h2, 32'hFFFFFFFD);
    calc_row(uop_pkg::FU_DIV, uop_pkg::DIV_REM,  32'hFFFFFFF9, 32'h2, 32'hFFFFFFFF);
    calc_row(uop_pkg::FU_DIV, uop_pkg::DIV_DIVU, 32'hFFFFFFF9, 32'h2, 32'h7FFFFFFC);
    calc_row(uop_pkg::FU_DIV, uop_pkg::DIV_REMU, 32'h64, 32'h7, 32'h2);
    calc_row(uop_pkg::FU_DIV, uop_pkg::DIV_DIV,  32'h80000000, 32'hFFFFFFFF, 32'h80000000);
    calc_row(uop_pkg::FU_DIV, uop_pkg::DIV_DIVU, 32'h1234, 32'h0, 32'hFFFFFFFF);
    calc_row(uop_pkg::FU_DIV, uop_pkg::DIV_REM,  32'hFFFFFFF9, 32'h0, 32'hFFFFFFF9);
    branch_row(uop_pkg::BR_EQ,  32'h900, 32'h40, 32'h5, 32'h6, 1'b0, 32'h0, 32'h0);
    branch_row(uop_pkg::BR_NE,  32'h940, 32'h8, 32'h77, 32'h77, 1'b0, 32'h0, 32'h0);
    branch_row(uop_pkg::BR_LT,  32'h980, 32'h8, 32'h1, 32'hFFFFFFFF, 1'b0, 32'h0, 32'h0);
    branch_row(uop_pkg::BR_LTU, 32'h9C0, 32'h4, 32'hFFFFFFFF, 32'h1, 1'b0, 32'h0, 32'h0);
    branch_row(uop_pkg::BR_GEU, 32'hA00, 32'h30, 32'hFFFFFFFE, 32'h3, 1'b1, 32'hA30, 32'h0);
    branch_row(uop_pkg::BR_GEU, 32'hA80, 32'h10, 32'h3, 32'hFFFFFFFE, 1'b0, 32'h0, 32'h0);
  endtask

  function automatic int latency_of(input uop_pkg::fu_code_t fu);
    case (fu)
      uop_pkg::FU_MUL: return `IMUL_LATENCY;
      uop_pkg::FU_DIV: return `IDIV_LATENCY;
      default:         return 1;
    endcase
  endfunction

  task automatic drive_row(input int i);
    uop.valid = 1'b1;
    uop.fu    = rows[i].fu;
    uop.op    = uop_pkg::fu_op_u'(rows[i].op);
    uop.rd    = 5'(i);
    uop.pc    = rows[i].pc;
    uop.imm   = rows[i].imm;
    in1       = rows[i].in1;
    in2       = rows[i].in2;
  endtask

  // idx is the branch accepted one cycle earlier, or -1
  task automatic check_redirect(input int idx);
    if (idx < 0) begin
      if (redirect.valid) begin
        errors++;
        $display("Error %0t: redirect with no branch accepted", $time);
      end
    end else if (redirect.valid !== rows[idx].has_redir) begin
      errors++;
      $display("Error %0t: row %0d redirect valid %b expected %b", $time, idx,
               redirect.valid, rows[idx].has_redir);
    end else if (redirect.valid && redirect.target !== rows[idx].exp_target) begin
      errors++;
      $display("Error %0t: row %0d target %h expected %h", $time, idx,
               redirect.target, rows[idx].exp_target);
    end
  endtask

  always @(negedge clock) begin
    int idx;
    if (!reset && wb.valid) begin
      idx = int'(wb.rd);
      if (!rows[idx].has_wb) begin
        errors++;
        $display("writeback for rd %0d, which writes no register", idx);
      end else if (done[idx]) begin
        errors++;
        $display("rd %0d was written more than once", idx);
      end else begin
        done[idx] = 1'b1;
        completions++;
        if (wb.data !== rows[idx].exp_data) begin
          errors++;
          $display("Error %0t: rd %0d data %h expected %h", $time, idx, wb.data,
                   rows[idx].exp_data);
        end
        if (cycle - acc_cycle[idx] != latency_of(rows[idx].fu)) begin
          errors++;
          $display("Error %0t: rd %0d took %0d cycles, expected %0d", $time, idx,
                   cycle - acc_cycle[idx], latency_of(rows[idx].fu));
        end
      end
    end
  end

  initial begin
    int   i;
    int   br_idx;
    logic accepted;
    clock = 1'b0;
    reset = 1'b1;
    uop   = '0;
    in1   = '0;
    in2   = '0;
    build_table();
    @(posedge clock);
    #1 drive_row(0);  // issuer already holds an op in reset
    repeat (9) @(posedge clock);
    #1 reset = 1'b0;
    i = 0;
    br_idx = -1;
    while (i < N_ROWS) begin
      drive_row(i);
      @(negedge clock);
      check_redirect(br_idx);
      br_idx = -1;
      accepted = !stall;
      if (accepted) acc_cycle[i] = cycle;
      else stalled[i] = 1'b1;
      @(posedge clock);
      #1;
      if (accepted) begin
        if (rows[i].fu == uop_pkg::FU_BR) br_idx = i;
        i++;
      end
    end
    uop = '0;
    @(negedge clock);
    check_redirect(br_idx);
    while (completions < n_wb) @(negedge clock);
    repeat (40) begin
      @(negedge clock);
      check_redirect(-1);  // drain, catches late duplicates too
    end
    if (!stalled[COLLIDE_ROW]) begin
      errors++;
      $display("alu op behind the multiplies was never stalled");
    end
    if (!stalled[DIV2_ROW]) begin
      errors++;
      $display("second divide was never stalled");
    end
    $display("errors %0d, completions %0d of %0d", errors, completions, n_wb);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(N_ROWS * 40 * 4);
    $display("run timed out with %0d of %0d completions", completions, n_wb);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/exec_unit_sva.sv
// writeback scheduler assertions
// one result per cycle, alu and multiply timing, stall in reset
`timescale 1ns/1ns
`default_nettype none
`include "exec_settings.svh"

module exec_unit_sva (
  input logic               clock,
  input logic               reset,
  input uop_pkg::micro_op_t uop,
  input logic               accept,
  input logic               stall,
  input exec_pkg::wb_t      alu_res,
  input exec_pkg::wb_t      br_res,
  input exec_pkg::wb_t      mul_res,
  input exec_pkg::wb_t      div_res,
  input exec_pkg::wb_t      wb
);

  one_result: assert property (@(posedge clock) disable iff (reset)
    $onehot0({alu_res.valid, br_res.valid, mul_res.valid, div_res.valid}))
    else $error("more than one unit result valid");

  alu_timing: assert property (@(posedge clock) disable iff (reset)
    (accept && uop.fu == uop_pkg::FU_ALU) |=> wb.valid)
    else $error("alu result missing one cycle after accept");

  mul_timing: assert property (@(posedge clock) disable iff (reset)
    (accept && uop.fu == uop_pkg::FU_MUL) |-> ##(`IMUL_LATENCY) mul_res.valid)
    else $error("multiply result late or missing");

  reset_stall: assert property (@(posedge clock) reset |-> !stall)
    else $error("stall high in reset");

endmodule

bind wb_scheduler exec_unit_sva sva_inst (
  .clock(clock), .reset(reset), .uop(uop), .accept(accept), .stall(stall),
  .alu_res(alu_res), .br_res(br_res), .mul_res(mul_res), .div_res(div_res), .wb(wb)
);

`default_nettype wire

// File: verilog/exec_unit.sv
// execute stage top
// four function units sharing one writeback port
`timescale 1ns/1ns
`default_nettype none

module exec_unit (
  input  logic                clock,
  input  logic                reset,
  input  uop_pkg::micro_op_t  uop,
  input  logic [31:0]         in1,
  input  logic [31:0]         in2,
  output logic                stall,
  output exec_pkg::wb_t       wb,
  output exec_pkg::redirect_t redirect
);

  logic          accept;
  exec_pkg::wb_t alu_res, br_res, mul_res, div_res;

  alu alu_inst (
    .clock(clock), .reset(reset), .accept(accept), .uop(uop),
    .in1(in1), .in2(in2), .result(alu_res)
  );

  branch_unit branch_unit_inst (
    .clock(clock), .reset(reset), .accept(accept), .uop(uop),
    .in1(in1), .in2(in2), .result(br_res), .redirect(redirect)
  );

  imul imul_inst (
    .clock(clock), .reset(reset), .accept(accept), .uop(uop),
    .in1(in1), .in2(in2), .result(mul_res)
  );

  idiv idiv_inst (
    .clock(clock), .reset(reset), .accept(accept), .uop(uop),
    .in1(in1), .in2(in2), .result(div_res)
  );

  wb_scheduler wb_scheduler_inst (
    .clock(clock), .reset(reset), .uop(uop),
    .alu_res(alu_res), .br_res(br_res), .mul_res(mul_res), .div_res(div_res),
    .stall(stall), .accept(accept), .wb(wb)
  );

endmodule

`default_nettype wire

// File: verilog/wb_scheduler.sv
// writeback scheduler
// reserves the result port per finishing cycle, stalls on conflicts
// and merges the unit results
`timescale 1ns/1ns
`default_nettype none
`include "exec_settings.svh"

module wb_scheduler (
  input  logic               clock,
  input  logic               reset,
  input  uop_pkg::micro_op_t uop,
  input  exec_pkg::wb_t      alu_res,
  input  exec_pkg::wb_t      br_res,
  input  exec_pkg::wb_t      mul_res,
  input  exec_pkg::wb_t      div_res,
  output logic               stall,
  output logic               accept,
  output exec_pkg::wb_t      wb
);

  localparam int RESV_W = `IDIV_LATENCY + 1;

  logic [RESV_W-1:0] resv;  // bit k, port taken k cycles from now
  logic [RESV_W-1:0] new_slot;
  logic [5:0]        lat;
  logic [5:0]        div_busy;
  logic              is_div;

  always_comb begin
    case (uop.fu)
      uop_pkg::FU_MUL: lat = 6'(`IMUL_LATENCY);
      uop_pkg::FU_DIV: lat = 6'(`IDIV_LATENCY);
      default:         lat = 6'd1;
    endcase
  end

  assign is_div   = uop.fu == uop_pkg::FU_DIV;
  assign stall    = uop.valid & (resv[lat] | (is_div & (div_busy != '0)));
  assign accept   = uop.valid & ~stall;
  assign new_slot = RESV_W'(1) << (lat - 6'd1);  // one cycle closer after the edge

  always_ff @(posedge clock) begin
    if (reset) begin
      resv     <= '0;
      div_busy <= '0;
    end else begin
      resv <= (resv >> 1) | (accept ? new_slot : '0);
      if (accept & is_div)
        div_busy <= 6'(`IDIV_LATENCY - 1);
      else if (div_busy != '0)
        div_busy <= div_busy - 6'd1;
    end
  end

  // at most one valid, guaranteed by resv
  assign wb = ({38{alu_res.valid}} & alu_res) | ({38{br_res.valid}} & br_res) |
              ({38{mul_res.valid}} & mul_res) | ({38{div_res.valid}} & div_res);

endmodule

`default_nettype wire

// File: verilog/idiv.sv
// radix-2 restoring divider
// works on magnitudes, signs applied in the last cycle
`timescale 1ns/1ns
`default_nettype none
`include "exec_settings.svh"

module idiv (
  input  logic                clock,
  input  logic                reset,
  input  logic                accept,
  input  uop_pkg::micro_op_t  uop,
  input  logic [31:0]         in1,
  input  logic [31:0]         in2,
  output exec_pkg::wb_t       result
);

  logic        start, signed_op, a_neg, b_neg;
  logic [31:0] a_mag, b_mag;
  logic [5:0]  cnt;  // remaining cycles
  logic [31:0] divisor, quot, rem;
  logic        q_neg, r_neg, is_rem;
  logic [4:0]  rd_q;
  logic [32:0] shifted;
  logic        fits;
  logic        valid_q;
  logic [4:0]  rd_out;
  logic [31:0] data_q;

  assign start     = accept & (uop.fu == uop_pkg::FU_DIV);
  assign signed_op = (uop.op.div == uop_pkg::DIV_DIV) | (uop.op.div == uop_pkg::DIV_REM);
  assign a_neg     = signed_op & in1[31];
  assign b_neg     = signed_op & in2[31];
  assign a_mag     = a_neg ? -in1 : in1;
  assign b_mag     = b_neg ? -in2 : in2;

  assign shifted = {rem, quot[31]};
  assign fits    = shifted >= {1'b0, divisor};

  always_ff @(posedge clock) begin
    if (reset) begin
      cnt     <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= cnt == 6'd1;
      if (start)
        cnt <= 6'(`IDIV_LATENCY - 1);
      else if (cnt != '0)
        cnt <= cnt - 6'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      divisor <= b_mag;
      quot    <= a_mag;
      rem     <= '0;
      // x/0 keeps an all-ones quotient, rem falls out as the dividend
      q_neg   <= (a_neg ^ b_neg) & (in2 != '0);
      r_neg   <= a_neg;
      is_rem  <= (uop.op.div == uop_pkg::DIV_REM) | (uop.op.div == uop_pkg::DIV_REMU);
      rd_q    <= uop.rd;
    end else if (cnt > 6'd1) begin
      rem  <= fits ? 32'(shifted - {1'b0, divisor}) : shifted[31:0];
      quot <= {quot[30:0], fits};
    end
    if (cnt == 6'd1) begin  // min int / -1 gives min int, rem 0 naturally
      data_q <= is_rem ? (r_neg ? -rem : rem) : (q_neg ? -quot : quot);
      rd_out <= rd_q;
    end
  end

  assign result = '{valid: valid_q, rd: rd_out, data: data_q};

endmodule

`default_nettype wire

// File: verilog/imul.sv
// pipelined 32x32 multiplier
// 33-bit extended operands cover mul, mulh, mulhsu and mulhu
`timescale 1ns/1ns
`default_nettype none
`include "exec_settings.svh"

module imul (
  input  logic                clock,
  input  logic                reset,
  input  logic                accept,
  input  uop_pkg::micro_op_t  uop,
  input  logic [31:0]         in1,
  input  logic [31:0]         in2,
  output exec_pkg::wb_t       result
);

  localparam int DEPTH = `IMUL_LATENCY;

  logic              start, a_signed, b_signed;
  logic [32:0]       a_ext, b_ext;
  logic [65:0]       product;
  logic [DEPTH-1:0]  valid_q;
  logic [DEPTH-1:0]  hi_q;
  logic [4:0]        rd_q   [DEPTH];
  logic [65:0]       prod_q [DEPTH];

  assign start    = accept & (uop.fu == uop_pkg::FU_MUL);
  assign a_signed = uop.op.mul != uop_pkg::MUL_MULHU;
  assign b_signed = (uop.op.mul == uop_pkg::MUL_MUL) | (uop.op.mul == uop_pkg::MUL_MULH);

  assign a_ext   = {a_signed & in1[31], in1};
  assign b_ext   = {b_signed & in2[31], in2};
  assign product = 66'($signed(a_ext) * $signed(b_ext));

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[DEPTH-2:0], start};
    end
  end

  always_ff @(posedge clock) begin
    hi_q      <= {hi_q[DEPTH-2:0], uop.op.mul != uop_pkg::MUL_MUL};
    rd_q[0]   <= uop.rd;
    prod_q[0] <= product;
    for (int i = 1; i < DEPTH; i++) begin
      rd_q[i]   <= rd_q[i-1];
      prod_q[i] <= prod_q[i-1];
    end
  end

  // high word for everything but mul
  assign result = '{valid: valid_q[DEPTH-1],
                    rd:    rd_q[DEPTH-1],
                    data:  hi_q[DEPTH-1] ? prod_q[DEPTH-1][63:32] : prod_q[DEPTH-1][31:0]};

endmodule

`default_nettype wire

// File: verilog/branch_unit.sv
// branch unit
// compare, target and link value, all registered
`timescale 1ns/1ns
`default_nettype none

module branch_unit (
  input  logic                clock,
  input  logic                reset,
  input  logic                accept,
  input  uop_pkg::micro_op_t  uop,
  input  logic [31:0]         in1,
  input  logic [31:0]         in2,
  output exec_pkg::wb_t       result,
  output exec_pkg::redirect_t redirect
);

  logic        eq, lt, ge, ltu, geu;
  logic        is_jal, is_jalr, taken, start;
  logic [31:0] target;
  logic        wb_valid_q, redir_valid_q;
  logic [4:0]  rd_q;
  logic [31:0] link_q, target_q;

  assign eq  = in1 == in2;
  assign lt  = $signed(in1) < $signed(in2);
  assign ge  = $signed(in1) >= $signed(in2);  // >= for bge, not >
  assign ltu = in1 < in2;
  assign geu = in1 >= in2;

  assign is_jal  = uop.op.br == uop_pkg::BR_JAL;
  assign is_jalr = uop.op.br == uop_pkg::BR_JALR;
  assign start   = accept & (uop.fu == uop_pkg::FU_BR);

  always_comb begin
    case (uop.op.br)
      uop_pkg::BR_EQ:  taken = eq;
      uop_pkg::BR_NE:  taken = ~eq;
      uop_pkg::BR_LT:  taken = lt;
      uop_pkg::BR_GE:  taken = ge;
      uop_pkg::BR_LTU: taken = ltu;
      uop_pkg::BR_GEU: taken = geu;
      default:         taken = is_jal | is_jalr;
    endcase
  end

  // jalr clears bit 0
  assign target = is_jalr ? ((in1 + uop.imm) & ~32'd1) : uop.pc + uop.imm;

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid_q    <= 1'b0;
      redir_valid_q <= 1'b0;
    end else begin
      wb_valid_q    <= start & (is_jal | is_jalr);  // link write only
      redir_valid_q <= start & taken;
    end
  end

  always_ff @(posedge clock) begin
    rd_q     <= uop.rd;
    link_q   <= uop.pc + 32'd4;
    target_q <= target;
  end

  assign result   = '{valid: wb_valid_q, rd: rd_q, data: link_q};
  assign redirect = '{valid: redir_valid_q, target: target_q};

endmodule

`default_nettype wire

// File: verilog/alu.sv
// integer ALU, one cycle, registered result
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  logic                clock,
  input  logic                reset,
  input  logic                accept,
  input  uop_pkg::micro_op_t  uop,
  input  logic [31:0]         in1,
  input  logic [31:0]         in2,
  output exec_pkg::wb_t       result
);

  logic [31:0] res;
  logic [4:0]  shamt;
  logic        valid_q;
  logic [4:0]  rd_q;
  logic [31:0] data_q;

  assign shamt = in2[4:0];  // upper bits ignored

  always_comb begin
    case (uop.op.alu)
      uop_pkg::ALU_ADD:  res = in1 + in2;
      uop_pkg::ALU_SUB:  res = in1 - in2;
      uop_pkg::ALU_SLT:  res = {31'b0, $signed(in1) < $signed(in2)};
      uop_pkg::ALU_SLTU: res = {31'b0, in1 < in2};
      uop_pkg::ALU_XOR:  res = in1 ^ in2;
      uop_pkg::ALU_OR:   res = in1 | in2;
      uop_pkg::ALU_AND:  res = in1 & in2;
      uop_pkg::ALU_SLL:  res = in1 << shamt;
      uop_pkg::ALU_SRL:  res = in1 >> shamt;
      uop_pkg::ALU_SRA:  res = $unsigned($signed(in1) >>> shamt);
      default:           res = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= accept & (uop.fu == uop_pkg::FU_ALU);
    end
  end

  always_ff @(posedge clock) begin
    rd_q   <= uop.rd;
    data_q <= res;
  end

  assign result = '{valid: valid_q, rd: rd_q, data: data_q};

endmodule

`default_nettype wire

// File: verilog/exec_pkg.sv
// execute stage outputs
// register writeback and fetch redirect
`default_nettype none

package exec_pkg;

  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] data;
  } wb_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] target;
  } redirect_t;

endpackage

`default_nettype wire

// File: verilog/uop_pkg.sv
// micro-op types for the execute stage
// one op field, decoded per function unit
`default_nettype none

package uop_pkg;

  typedef enum logic [1:0] {
    FU_ALU, FU_BR, FU_MUL, FU_DIV
  } fu_code_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA
  } alu_op_t;

  typedef enum logic [3:0] {
    BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
  } br_op_t;

  typedef enum logic [3:0] {
    MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU
  } mul_op_t;

  typedef enum logic [3:0] {
    DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU
  } div_op_t;

  // same 4 bits, meaning depends on fu
  typedef union packed {
    alu_op_t alu;
    br_op_t  br;
    mul_op_t mul;
    div_op_t div;
  } fu_op_u;

  typedef struct packed {
    logic        valid;
    fu_code_t    fu;
    fu_op_u      op;
    logic [4:0]  rd;   // destination tag
    logic [31:0] pc;
    logic [31:0] imm;
  } micro_op_t;

endpackage

`default_nettype wire

// File: verilog/exec_settings.svh
// execute stage settings
// unit latencies shared by the units and the writeback scheduler
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// cycles from accept to multiply result, at least 2
`define IMUL_LATENCY 3

// load, 32 shift-subtract steps, sign fix
`define IDIV_LATENCY 34

`endif
